// ==== hdl/filter_pkg.sv ====
/*
 * Shared sizes and types for the RAM-based counting filter.
 * The defaults here are only defaults: filter_top passes its own values down.
 * RAM_READ_LATENCY describes bucket_ram and must change together with it.
 */

`default_nettype none

package filter_pkg;

    // ==============================
    // Default sizes
    // ==============================

    // Number of buckets, one counter each
    parameter int DEF_N_BUCKETS = 16;

    // Width of each bucket counter
    parameter int DEF_BUCKET_BITS = 4;

    // Entries in the queue that holds removes waiting for a free update slot
    parameter int DEF_REMOVE_DEPTH = 8;

    // Cycles from read address to read data in bucket_ram
    // Both the update pipe and the lookup ports track this many stages of writes
    parameter int RAM_READ_LATENCY = 2;

    // ==============================
    // Update opcodes
    // ==============================

    // What one slot of the update pipeline carries
    // OP_NONE marks an idle slot, which never writes the RAM
    typedef enum logic [1:0]
    {
        OP_NONE,
        OP_INSERT,
        OP_REMOVE
    } upd_op_t;

endpackage

`default_nettype wire

// ==== hdl/bucket_ram.sv ====
/*
 * Simple dual-port RAM: read address and read data are both registered.
 * Writes are registered once more before they reach the array.
 * After reset every entry is written with INIT_VALUE, one per cycle,
 * and rdy stays low for N_ENTRIES cycles. N_ENTRIES must be at least 2.
 */

`timescale 1ns/1ns
`default_nettype none

module bucket_ram
#(
    parameter int                N_ENTRIES  = 16,
    parameter int                WIDTH      = 4,
    parameter logic [WIDTH-1:0]  INIT_VALUE = '0
)
(
    input  logic                         clk,
    input  logic                         reset,
    output logic                         rdy,
    input  logic [$clog2(N_ENTRIES)-1:0] raddr,
    output logic [WIDTH-1:0]             rdata,
    input  logic                         wen,
    input  logic [$clog2(N_ENTRIES)-1:0] waddr,
    input  logic [WIDTH-1:0]             wdata
);

    localparam int IDX_W = $clog2(N_ENTRIES);

    logic [WIDTH-1:0] mem [N_ENTRIES];

    // Read side registers
    logic [IDX_W-1:0] raddr_q;

    // Write side registers, loaded from either the sweep or the client port
    logic             wen_q;
    logic [IDX_W-1:0] waddr_q;
    logic [WIDTH-1:0] wdata_q;

    // Sweep position while the RAM clears itself
    logic [IDX_W-1:0] clr_idx;

    // ==============================
    // Clearing sweep
    // ==============================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rdy     <= 1'b0;
            clr_idx <= '0;
        end
        else if (!rdy)
        begin
            clr_idx <= clr_idx + 1'b1;
            // The last entry is queued this cycle, so the next one is usable
            rdy     <= (clr_idx == IDX_W'(N_ENTRIES - 1));
        end
    end

    // ==============================
    // Array access
    // ==============================

    always_ff @(posedge clk)
    begin
        // While the sweep runs it owns the write port
        waddr_q <= rdy ? waddr : clr_idx;
        wdata_q <= rdy ? wdata : INIT_VALUE;
        wen_q   <= !rdy || wen;
        if (reset)
        begin
            wen_q <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wen_q)
        begin
            mem[waddr_q] <= wdata_q;
        end
        raddr_q <= raddr;
        rdata   <= mem[raddr_q];
    end

    // Clients must hold off until the sweep is over, or their writes are lost
    a_no_write_before_rdy: assert property (@(posedge clk) disable iff (reset)
        !rdy |-> !wen)
        else $error("bucket_ram write to %0d while clearing", waddr);

endmodule

`default_nettype wire

// ==== hdl/update_arbiter.sv ====
/*
 * Shares the one update slot between inserts and queued removes.
 * Inserts always win; a client that inserts every cycle starves removes.
 * Pushing a remove while remove_not_full is low is a client error.
 */

`timescale 1ns/1ns
`default_nettype none

module update_arbiter
#(
    parameter int N_BUCKETS    = filter_pkg::DEF_N_BUCKETS,
    parameter int REMOVE_DEPTH = filter_pkg::DEF_REMOVE_DEPTH
)
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         insert_en,
    input  logic [$clog2(N_BUCKETS)-1:0] insert_idx,
    input  logic                         remove_en,
    input  logic [$clog2(N_BUCKETS)-1:0] remove_idx,
    output logic                         remove_not_full,
    output filter_pkg::upd_op_t          grant_op,
    output logic [$clog2(N_BUCKETS)-1:0] grant_idx
);

    import filter_pkg::*;

    localparam int IDX_W = $clog2(N_BUCKETS);
    localparam int PTR_W = (REMOVE_DEPTH > 1) ? $clog2(REMOVE_DEPTH) : 1;
    localparam int CNT_W = $clog2(REMOVE_DEPTH + 1);

    // Circular queue of bucket indices waiting to be removed
    logic [IDX_W-1:0] queue [REMOVE_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    logic push;
    logic pop;
    logic not_empty;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(REMOVE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign not_empty       = (count != '0);
    assign remove_not_full = (count != CNT_W'(REMOVE_DEPTH));
    assign push            = remove_en && remove_not_full;
    // The head leaves the queue in the same cycle it is granted
    assign pop             = !insert_en && not_empty;

    // ==============================
    // Grant selection
    // ==============================

    always_comb
    begin
        grant_idx = queue[rd_ptr];
        if (insert_en)
        begin
            grant_op  = OP_INSERT;
            grant_idx = insert_idx;
        end
        else if (not_empty)
        begin
            grant_op = OP_REMOVE;
        end
        else
        begin
            grant_op = OP_NONE;
        end
    end

    // ==============================
    // Queue state
    // ==============================

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            queue[wr_ptr] <= remove_idx;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop)
            begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // A push and a pop together leave the occupancy unchanged
            if (push && !pop)
            begin
                count <= count + 1'b1;
            end
            else if (pop && !push)
            begin
                count <= count - 1'b1;
            end
        end
    end

    a_no_push_when_full: assert property (@(posedge clk) disable iff (reset)
        remove_en |-> remove_not_full)
        else $error("Remove of bucket %0d pushed into a full queue", remove_idx);

endmodule

`default_nettype wire

// ==== hdl/update_pipe.sv ====
/*
 * Read-modify-write pipeline for bucket counters.
 * A grant in cycle t reads in t, builds its delta in t+1 and writes in t+2.
 * The delta folds in every update still in flight to the same bucket,
 * so one update per cycle is sustained with no stalls.
 */

`timescale 1ns/1ns
`default_nettype none

module update_pipe
#(
    parameter int N_BUCKETS   = filter_pkg::DEF_N_BUCKETS,
    parameter int BUCKET_BITS = filter_pkg::DEF_BUCKET_BITS
)
(
    input  logic                         clk,
    input  logic                         reset,
    input  filter_pkg::upd_op_t          grant_op,
    input  logic [$clog2(N_BUCKETS)-1:0] grant_idx,
    output logic                         rdy,
    output logic                         wr_en,
    output logic [$clog2(N_BUCKETS)-1:0] wr_idx,
    output logic [BUCKET_BITS-1:0]       wr_value,
    output logic                         wr_is_zero
);

    import filter_pkg::*;

    localparam int IDX_W = $clog2(N_BUCKETS);

    // Last stage whose write the RAM read of stage 1 cannot yet see
    localparam int LAST_STAGE = RAM_READ_LATENCY + 1;

    // Opcode and bucket of each update, stage 1 is one cycle after the grant
    upd_op_t          op_s  [1:LAST_STAGE];
    logic [IDX_W-1:0] idx_s [1:LAST_STAGE];

    // Delta built in stage 1 and carried to the write stage
    logic [BUCKET_BITS-1:0] delta_new;
    logic [BUCKET_BITS-1:0] delta_s [2:RAM_READ_LATENCY];

    logic [BUCKET_BITS-1:0] rd_value;

    // This RAM sweeps in step with the lookup copies, so its rdy speaks for all
    bucket_ram
    #(
        .N_ENTRIES  (N_BUCKETS),
        .WIDTH      (BUCKET_BITS),
        .INIT_VALUE ('0)
    )
    u_ram
    (
        .clk   (clk),
        .reset (reset),
        .rdy   (rdy),
        .raddr (grant_idx),
        .rdata (rd_value),
        .wen   (wr_en),
        .waddr (wr_idx),
        .wdata (wr_value)
    );

    // ==============================
    // Stage tracking
    // ==============================

    always_ff @(posedge clk)
    begin
        op_s[1]  <= grant_op;
        idx_s[1] <= grant_idx;
        for (int p = 2; p <= LAST_STAGE; p++)
        begin
            op_s[p]  <= op_s[p-1];
            idx_s[p] <= idx_s[p-1];
        end
        if (reset)
        begin
            for (int p = 1; p <= LAST_STAGE; p++)
            begin
                op_s[p] <= OP_NONE;
            end
        end
    end

    // ==============================
    // In-flight delta
    // ==============================

    // Stage 1 counts itself; older stages count only when they hit its bucket
    // Their writes are still on the way and absent from the RAM data
    always_comb
    begin
        delta_new = '0;
        for (int p = 1; p <= LAST_STAGE; p++)
        begin
            if ((p == 1) || (idx_s[p] == idx_s[1]))
            begin
                if (op_s[p] == OP_INSERT)
                begin
                    delta_new = delta_new + BUCKET_BITS'(1);
                end
                else if (op_s[p] == OP_REMOVE)
                begin
                    delta_new = delta_new - BUCKET_BITS'(1);
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        delta_s[2] <= delta_new;
        for (int p = 3; p <= RAM_READ_LATENCY; p++)
        begin
            delta_s[p] <= delta_s[p-1];
        end
    end

    // ==============================
    // Write bus
    // ==============================

    // Modulo arithmetic is exact while the client keeps buckets in range
    assign wr_en      = (op_s[RAM_READ_LATENCY] != OP_NONE);
    assign wr_idx     = idx_s[RAM_READ_LATENCY];
    assign wr_value   = rd_value + delta_s[RAM_READ_LATENCY];
    assign wr_is_zero = (wr_value == '0);

    // An insert that lands on zero has wrapped past the maximum
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        (wr_en && (op_s[RAM_READ_LATENCY] == OP_INSERT)) |-> (wr_value != '0))
        else $error("Bucket %0d overflow", wr_idx);

    // A remove that lands on all ones has wrapped below zero
    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        (wr_en && (op_s[RAM_READ_LATENCY] == OP_REMOVE)) |-> !(&wr_value))
        else $error("Bucket %0d underflow", wr_idx);

endmodule

`default_nettype wire

// ==== hdl/lookup_port.sv ====
/*
 * One lookup port with its own RAM copy fed from the shared write bus.
 * A request in cycle t shows its result in t+2 and reflects every update
 * granted before t. The port looks up every cycle; it has no enable.
 */

`timescale 1ns/1ns
`default_nettype none

module lookup_port
#(
    parameter int               N_BUCKETS  = filter_pkg::DEF_N_BUCKETS,
    parameter int               WIDTH      = filter_pkg::DEF_BUCKET_BITS,
    parameter logic [WIDTH-1:0] INIT_VALUE = '0
)
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic [$clog2(N_BUCKETS)-1:0] req_idx,
    input  logic                         wr_en,
    input  logic [$clog2(N_BUCKETS)-1:0] wr_idx,
    input  logic [WIDTH-1:0]             wr_data,
    output logic [WIDTH-1:0]             result
);

    import filter_pkg::*;

    localparam int IDX_W = $clog2(N_BUCKETS);

    // Bucket of the request as it moves through the read latency
    logic [IDX_W-1:0] trk_idx [1:RAM_READ_LATENCY-1];

    // Newest bus write seen for that bucket, per stage
    logic             trk_hit [1:RAM_READ_LATENCY];
    logic [WIDTH-1:0] trk_val [1:RAM_READ_LATENCY];

    logic [WIDTH-1:0] ram_data;

    bucket_ram
    #(
        .N_ENTRIES  (N_BUCKETS),
        .WIDTH      (WIDTH),
        .INIT_VALUE (INIT_VALUE)
    )
    u_ram
    (
        .clk   (clk),
        .reset (reset),
        .rdy   (),
        .raddr (req_idx),
        .rdata (ram_data),
        .wen   (wr_en),
        .waddr (wr_idx),
        .wdata (wr_data)
    );

    // ==============================
    // Bypass tracking
    // ==============================

    // Writes on the bus during the read latency miss the RAM read, so catch them
    always_ff @(posedge clk)
    begin
        trk_hit[1] <= wr_en && (wr_idx == req_idx);
        trk_val[1] <= wr_data;
        for (int p = 2; p < RAM_READ_LATENCY; p++)
        begin
            trk_idx[p] <= trk_idx[p-1];
        end
        trk_idx[1] <= req_idx;
        for (int p = 2; p <= RAM_READ_LATENCY; p++)
        begin
            trk_hit[p] <= trk_hit[p-1];
            trk_val[p] <= trk_val[p-1];
            // A later write to the same bucket supersedes an earlier capture
            if (wr_en && (wr_idx == trk_idx[p-1]))
            begin
                trk_hit[p] <= 1'b1;
                trk_val[p] <= wr_data;
            end
        end
        if (reset)
        begin
            for (int p = 1; p <= RAM_READ_LATENCY; p++)
            begin
                trk_hit[p] <= 1'b0;
            end
        end
    end

    assign result = trk_hit[RAM_READ_LATENCY] ? trk_val[RAM_READ_LATENCY] : ram_data;

endmodule

`default_nettype wire

// ==== hdl/filter_top.sv ====
/*
 * Single-bank counting filter in RAM with insert, remove and two lookups.
 * Strobes are ignored until rdy rises, N_BUCKETS cycles after reset.
 * Clients must keep every bucket within 0 and its maximum.
 */

`timescale 1ns/1ns
`default_nettype none

module filter_top
#(
    parameter int N_BUCKETS    = filter_pkg::DEF_N_BUCKETS,
    parameter int BUCKET_BITS  = filter_pkg::DEF_BUCKET_BITS,
    parameter int REMOVE_DEPTH = filter_pkg::DEF_REMOVE_DEPTH
)
(
    input  logic                         clk,
    input  logic                         reset,
    output logic                         rdy,
    input  logic                         insert_en,
    input  logic [$clog2(N_BUCKETS)-1:0] insert_idx,
    input  logic                         remove_en,
    input  logic [$clog2(N_BUCKETS)-1:0] remove_idx,
    output logic                         remove_not_full,
    input  logic                         test_value_en,
    input  logic [$clog2(N_BUCKETS)-1:0] test_value_idx,
    output logic [BUCKET_BITS-1:0]       test_value,
    input  logic                         test_zero_en,
    input  logic [$clog2(N_BUCKETS)-1:0] test_zero_idx,
    output logic                         test_is_zero
);

    import filter_pkg::*;

    localparam int IDX_W = $clog2(N_BUCKETS);

    // Update requests only count once the RAMs have cleared
    wire insert_go = rdy && insert_en;
    wire remove_go = rdy && remove_en;

    // An idle lookup port parks on bucket 0 and its result is unused
    wire [IDX_W-1:0] value_req = test_value_en ? test_value_idx : '0;
    wire [IDX_W-1:0] zero_req  = test_zero_en ? test_zero_idx : '0;

    upd_op_t          grant_op;
    logic [IDX_W-1:0] grant_idx;

    // Shared write bus from the update pipe to every RAM copy
    logic                   wr_en;
    logic [IDX_W-1:0]       wr_idx;
    logic [BUCKET_BITS-1:0] wr_value;
    logic                   wr_is_zero;

    update_arbiter
    #(
        .N_BUCKETS    (N_BUCKETS),
        .REMOVE_DEPTH (REMOVE_DEPTH)
    )
    u_arbiter
    (
        .clk             (clk),
        .reset           (reset),
        .insert_en       (insert_go),
        .insert_idx      (insert_idx),
        .remove_en       (remove_go),
        .remove_idx      (remove_idx),
        .remove_not_full (remove_not_full),
        .grant_op        (grant_op),
        .grant_idx       (grant_idx)
    );

    update_pipe
    #(
        .N_BUCKETS   (N_BUCKETS),
        .BUCKET_BITS (BUCKET_BITS)
    )
    u_update_pipe
    (
        .clk        (clk),
        .reset      (reset),
        .grant_op   (grant_op),
        .grant_idx  (grant_idx),
        .rdy        (rdy),
        .wr_en      (wr_en),
        .wr_idx     (wr_idx),
        .wr_value   (wr_value),
        .wr_is_zero (wr_is_zero)
    );

    // Full counter copy for value lookups
    lookup_port
    #(
        .N_BUCKETS  (N_BUCKETS),
        .WIDTH      (BUCKET_BITS),
        .INIT_VALUE ('0)
    )
    u_value_port
    (
        .clk     (clk),
        .reset   (reset),
        .req_idx (value_req),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (wr_value),
        .result  (test_value)
    );

    // One-bit copy that stores "is zero" directly, so buckets start at 1
    lookup_port
    #(
        .N_BUCKETS  (N_BUCKETS),
        .WIDTH      (1),
        .INIT_VALUE (1'b1)
    )
    u_zero_port
    (
        .clk     (clk),
        .reset   (reset),
        .req_idx (zero_req),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (wr_is_zero),
        .result  (test_is_zero)
    );

endmodule

`default_nettype wire

// ==== bench/tb_filter.sv ====
/*
 * Testbench for filter_top at the package default sizes.
 * Lookups are checked only where the count is fixed. That needs no remove
 * for the bucket still waiting in the queue, unless inserts run every cycle.
 * Random stimulus comes from $random with a fixed seed.
 */

`timescale 1ns/1ns
`default_nettype none

module tb_filter;

    import filter_pkg::*;

    localparam int N_BUCKETS     = DEF_N_BUCKETS;
    localparam int BUCKET_BITS   = DEF_BUCKET_BITS;
    localparam int REMOVE_DEPTH  = DEF_REMOVE_DEPTH;
    localparam int IDX_W         = $clog2(N_BUCKETS);
    localparam int MAX_COUNT     = (1 << BUCKET_BITS) - 1;
    localparam int CLK_PERIOD    = 40;
    localparam int DRAIN_CYCLES  = REMOVE_DEPTH + 4;
    localparam int INSERT_RUN    = REMOVE_DEPTH + 4;
    localparam int RANDOM_CYCLES = 48;

    // Cycle budget of reset, sweep and the five tests, plus the closing wait
    localparam int RUN_CYCLES = 4 + N_BUCKETS + 1
        + (N_BUCKETS + 4)
        + (9 + 4)
        + (5 + 7 + DRAIN_CYCLES + N_BUCKETS + 4)
        + (INSERT_RUN + DRAIN_CYCLES + 1 + 4)
        + (RANDOM_CYCLES + DRAIN_CYCLES + N_BUCKETS + 4)
        + 4;
    localparam int WATCHDOG_CYCLES = RUN_CYCLES + 100;

    logic                   clk;
    logic                   reset;
    logic                   rdy;
    logic                   insert_en;
    logic [IDX_W-1:0]       insert_idx;
    logic                   remove_en;
    logic [IDX_W-1:0]       remove_idx;
    logic                   remove_not_full;
    logic                   test_value_en;
    logic [IDX_W-1:0]       test_value_idx;
    logic [BUCKET_BITS-1:0] test_value;
    logic                   test_zero_en;
    logic [IDX_W-1:0]       test_zero_idx;
    logic                   test_is_zero;

    // Expectations captured in the request cycle, then delayed to the result cycle
    logic                   chk_value;
    logic [BUCKET_BITS-1:0] exp_value;
    logic                   chk_zero;
    logic                   exp_zero;
    logic                   chk_value_d1;
    logic                   chk_value_d2;
    logic [BUCKET_BITS-1:0] exp_value_d1;
    logic [BUCKET_BITS-1:0] exp_value_d2;
    logic                   chk_zero_d1;
    logic                   chk_zero_d2;
    logic                   exp_zero_d1;
    logic                   exp_zero_d2;
    logic                   nf_chk;
    logic                   exp_nf;

    // Reference model
    // base holds inserts plus removes known to be applied, pend the removes still queued
    int   base [N_BUCKETS];
    int   pend [N_BUCKETS];
    int   occ;
    logic frozen;

    int seed = 22;
    int checks = 0;
    int errors = 0;
    int tests_run = 0;
    int mark_checks = 0;
    int mark_errors = 0;

    filter_top
    #(
        .N_BUCKETS    (N_BUCKETS),
        .BUCKET_BITS  (BUCKET_BITS),
        .REMOVE_DEPTH (REMOVE_DEPTH)
    )
    u_dut
    (
        .clk             (clk),
        .reset           (reset),
        .rdy             (rdy),
        .insert_en       (insert_en),
        .insert_idx      (insert_idx),
        .remove_en       (remove_en),
        .remove_idx      (remove_idx),
        .remove_not_full (remove_not_full),
        .test_value_en   (test_value_en),
        .test_value_idx  (test_value_idx),
        .test_value      (test_value),
        .test_zero_en    (test_zero_en),
        .test_zero_idx   (test_zero_idx),
        .test_is_zero    (test_is_zero)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    // ==============================
    // Checking
    // ==============================

    // Lookup results appear two cycles after the request
    always @(posedge clk)
    begin
        chk_value_d1 <= chk_value;
        chk_value_d2 <= chk_value_d1;
        exp_value_d1 <= exp_value;
        exp_value_d2 <= exp_value_d1;
        chk_zero_d1  <= chk_zero;
        chk_zero_d2  <= chk_zero_d1;
        exp_zero_d1  <= exp_zero;
        exp_zero_d2  <= exp_zero_d1;
        if (reset)
        begin
            chk_value_d1 <= 1'b0;
            chk_value_d2 <= 1'b0;
            chk_zero_d1  <= 1'b0;
            chk_zero_d2  <= 1'b0;
        end
        else
        begin
            checks <= checks + int'(chk_value_d2) + int'(chk_zero_d2) + int'(nf_chk);
        end
    end

    a_value: assert property (@(posedge clk) disable iff (reset)
        chk_value_d2 |-> (test_value == exp_value_d2))
        else
        begin
            errors = errors + 1;
            $display("Mismatch at %0t: test_value is %0d, expected %0d",
                $time, $sampled(test_value), $sampled(exp_value_d2));
        end

    a_zero: assert property (@(posedge clk) disable iff (reset)
        chk_zero_d2 |-> (test_is_zero == exp_zero_d2))
        else
        begin
            errors = errors + 1;
            $display("Mismatch at %0t: test_is_zero is %0b, expected %0b",
                $time, $sampled(test_is_zero), $sampled(exp_zero_d2));
        end

    // The queue fills and drains by the arbitration rules, so its level is known every cycle
    a_not_full: assert property (@(posedge clk) disable iff (reset)
        nf_chk |-> (remove_not_full == exp_nf))
        else
        begin
            errors = errors + 1;
            $display("Mismatch at %0t: remove_not_full is %0b, expected %0b",
                $time, $sampled(remove_not_full), $sampled(exp_nf));
        end

    a_rdy_holds: assert property (@(posedge clk) disable iff (reset)
        $past(rdy) |-> rdy)
        else
        begin
            errors = errors + 1;
            $display("rdy fell at %0t after the clearing sweep had finished", $time);
        end

    // ==============================
    // Stimulus helpers
    // ==============================

    function automatic logic [IDX_W-1:0] random_bucket();
        return IDX_W'($unsigned($random(seed)) % N_BUCKETS);
    endfunction

    // One clock of stimulus, with the model stepped after the expectation is taken
    task automatic drive_cycle(
        input logic             ins,
        input logic [IDX_W-1:0] ins_b,
        input logic             rm,
        input logic [IDX_W-1:0] rm_b,
        input logic             look,
        input logic [IDX_W-1:0] look_b
    );
        logic known;
        logic pop;
        @(posedge clk);
        known = look && ((pend[look_b] == 0) || frozen);
        pop   = !ins && (occ > 0);
        insert_en      <= ins;
        insert_idx     <= ins_b;
        remove_en      <= rm;
        remove_idx     <= rm_b;
        test_value_en  <= look;
        test_value_idx <= look_b;
        test_zero_en   <= look;
        test_zero_idx  <= look_b;
        chk_value      <= known;
        exp_value      <= BUCKET_BITS'(base[look_b]);
        chk_zero       <= known;
        exp_zero       <= (base[look_b] == 0);
        nf_chk         <= 1'b1;
        exp_nf         <= (occ < REMOVE_DEPTH);
        // This cycle's insert is granted now, so only later lookups count it
        if (ins)
        begin
            base[ins_b] = base[ins_b] + 1;
        end
        if (rm)
        begin
            pend[rm_b] = pend[rm_b] + 1;
        end
        occ = occ + int'(rm) - int'(pop);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles)
        begin
            drive_cycle(1'b0, '0, 1'b0, '0, 1'b0, '0);
        end
    endtask

    // After this quiet window the queue is empty and every remove has landed
    task automatic drain_removes();
        idle(DRAIN_CYCLES);
        for (int b = 0; b < N_BUCKETS; b++)
        begin
            base[b] = base[b] - pend[b];
            pend[b] = 0;
        end
    endtask

    task automatic sweep_lookups();
        for (int b = 0; b < N_BUCKETS; b++)
        begin
            drive_cycle(1'b0, '0, 1'b0, '0, 1'b1, IDX_W'(b));
        end
    endtask

    task automatic finish_test(input string name);
        // The last lookup is judged three edges after it is driven, one more lets its count settle
        idle(4);
        tests_run = tests_run + 1;
        $display("Test %0d %s: %0d checks, %0d errors",
            tests_run, name, checks - mark_checks, errors - mark_errors);
        mark_checks = checks;
        mark_errors = errors;
    endtask

    // ==============================
    // Test sequence
    // ==============================

    initial
    begin
        int               k;
        int               low_cycles;
        int               ins_list [5];
        int               rm_list [7];
        logic [31:0]      r;
        logic             ins;
        logic             rm;
        logic [IDX_W-1:0] ib;
        logic [IDX_W-1:0] rb;
        logic [IDX_W-1:0] lb;

        ins_list       = '{1, 1, 2, 2, 3};
        rm_list        = '{5, 5, 5, 1, 1, 2, 3};
        reset          = 1'b1;
        insert_en      = 1'b0;
        insert_idx     = '0;
        remove_en      = 1'b0;
        remove_idx     = '0;
        test_value_en  = 1'b0;
        test_value_idx = '0;
        test_zero_en   = 1'b0;
        test_zero_idx  = '0;
        chk_value      = 1'b0;
        exp_value      = '0;
        chk_zero       = 1'b0;
        exp_zero       = 1'b0;
        nf_chk         = 1'b0;
        exp_nf         = 1'b1;
        frozen         = 1'b0;
        occ            = 0;
        for (int b = 0; b < N_BUCKETS; b++)
        begin
            base[b] = 0;
            pend[b] = 0;
        end

        repeat (4) @(posedge clk);
        reset <= 1'b0;

        // Test 1 expects rdy low for one cycle per bucket, then every bucket reading zero
        low_cycles = 0;
        @(posedge clk);
        while (!rdy)
        begin
            low_cycles = low_cycles + 1;
            @(posedge clk);
        end
        assert (low_cycles == N_BUCKETS)
        else
        begin
            errors = errors + 1;
            $display("rdy rose after %0d cycles instead of %0d", low_cycles, N_BUCKETS);
        end
        sweep_lookups();
        finish_test("reset clearing");

        // Test 2 puts six inserts into one bucket and looks it up every cycle
        for (k = 0; k < 9; k++)
        begin
            drive_cycle(k < 6, IDX_W'(5), 1'b0, '0, 1'b1, IDX_W'(5));
        end
        finish_test("insert bypass");

        // Test 3 queues removes with no inserts and lets them drain
        for (k = 0; k < 5; k++)
        begin
            drive_cycle(1'b1, IDX_W'(ins_list[k]), 1'b0, '0, 1'b1, IDX_W'(ins_list[k]));
        end
        for (k = 0; k < 7; k++)
        begin
            drive_cycle(1'b0, '0, 1'b1, IDX_W'(rm_list[k]), 1'b0, '0);
        end
        drain_removes();
        sweep_lookups();
        finish_test("remove queue");

        // Test 4 inserts every cycle, which starves removes until the queue fills
        frozen = 1'b1;
        for (k = 0; k < INSERT_RUN; k++)
        begin
            drive_cycle(1'b1, IDX_W'(7), k < REMOVE_DEPTH, IDX_W'(7), 1'b1, IDX_W'(7));
        end
        frozen = 1'b0;
        drain_removes();
        drive_cycle(1'b0, '0, 1'b0, '0, 1'b1, IDX_W'(7));
        finish_test("insert priority");

        // Test 5 runs a random mix that never leaves the legal range of any bucket
        for (k = 0; k < RANDOM_CYCLES; k++)
        begin
            r   = $random(seed);
            ib  = random_bucket();
            rb  = random_bucket();
            lb  = random_bucket();
            ins = r[0] && (base[ib] < MAX_COUNT);
            // A remove is safe if the bucket stays positive even after all queued removes
            rm  = r[1] && (occ < REMOVE_DEPTH) && ((base[rb] - pend[rb]) > 0);
            drive_cycle(ins, ib, rm, rb, 1'b1, lb);
        end
        drain_removes();
        sweep_lookups();
        finish_test("random mix");

        @(posedge clk);
        nf_chk <= 1'b0;
        repeat (3) @(posedge clk);
        $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0)
        begin
            $display("SIMULATION PASSED");
        end
        else
        begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
hdl/filter_pkg.sv
hdl/bucket_ram.sv
hdl/update_arbiter.sv
hdl/update_pipe.sv
hdl/lookup_port.sv
hdl/filter_top.sv
bench/tb_filter.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the counting filter testbench with Verilator, runs it and looks for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module tb_filter -o tb_filter \
    || { echo "Verilator build failed"; exit 1; }

sim_out=$(./obj_dir/tb_filter)
echo "$sim_out"
echo "$sim_out" | grep -qx "SIMULATION PASSED" && exit 0 || exit 1
